//--- fsq_assert.sv
module fsq_assert (
    input logic                clk,
    input logic                rst,
    input logic                bpu_stall,
    input fsq_pkg::fsq_ptr_t   bpu_ptr,
    input fsq_pkg::cache_req_t cache_req,
    input logic                cache_ready,
    input fsq_pkg::redirect_t  redirect
);
    import fsq_pkg::*;

    // request holds while the cache stalls it
    hold_req: assert property (@(posedge clk) disable iff (rst)
        cache_req.valid && !cache_ready && !redirect.valid |=> $stable(cache_req))
        else $error("cache request changed while cache_ready was low");

    flush_req: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |=> !cache_req.valid)
        else $error("cache request still valid after a redirect");

    // a full queue takes no write
    stall_tail: assert property (@(posedge clk) disable iff (rst)
        bpu_stall && !redirect.valid |=> $stable(bpu_ptr))
        else $error("tail moved while the queue was full");

    // tail restarts right after the redirected stream
    redirect_tail: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |=> bpu_ptr == fsq_ptr_t'($past(redirect.ptr) + 1'b1))
        else $error("tail did not restart after the redirected stream");

endmodule

bind fsq_top fsq_assert u_assert (
    .clk(clk),
    .rst(rst),
    .bpu_stall(bpu_stall),
    .bpu_ptr(bpu_ptr),
    .cache_req(cache_req),
    .cache_ready(cache_ready),
    .redirect(redirect)
);

//--- fsq_clock_gen.sv
module fsq_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // reset spans 8 rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- fsq_commit.sv
module fsq_commit (
    input  logic                                          clk,
    input  logic                                          rst,
    input  fsq_pkg::fsq_ptr_t                             commit_head,
    input  fsq_pkg::fetch_stream_t                        commit_stream,
    input  fsq_pkg::redirect_t                            redirect,
    input  logic                                          enq,
    input  fsq_pkg::fsq_ptr_t                             tail,
    input  logic [$clog2(fsq_pkg::commit_width + 1)-1:0] commit_num,
    output logic                                          commit,
    output logic                                          update_valid,
    output fsq_pkg::update_t                              update
);
    import fsq_pkg::*;

    logic [commit_cnt_width-1:0] retired_cnt;
    logic [commit_cnt_width-1:0] retired_total;
    logic [commit_cnt_width-1:0] end_count;
    logic [fsq_size-1:0]         mispred;
    logic                        head_mispred;
    logic [pred_width-1:0]       end_offset;
    logic                        not_empty;
    wb_info_t                    wb_wdata;
    wb_info_t                    commit_wb;

    assign wb_wdata = '{taken: redirect.taken, target: redirect.target, offset: redirect.offset};

    // real outcome of each mispredicted stream
    fsq_ram #(
        .entry_t(wb_info_t)
    ) u_wb_ram (
        .clk(clk),
        .rst(rst),
        .we(redirect.valid),
        .waddr(redirect.ptr.idx),
        .wdata(wb_wdata),
        .raddr_a(commit_head.idx),
        .raddr_b(commit_head.idx),
        .rdata_a(commit_wb),
        .rdata_b()
    );

    // cleared on enqueue, set by a redirect naming the entry
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mispred <= '0;
        end else begin
            if (enq) begin
                mispred[tail.idx] <= 1'b0;
            end
            if (redirect.valid) begin
                mispred[redirect.ptr.idx] <= 1'b1;
            end
        end
    end

    assign head_mispred = mispred[commit_head.idx];
    assign end_offset = head_mispred ? commit_wb.offset : commit_stream.size;
    assign end_count = commit_cnt_width'(end_offset) + 1'b1;
    assign not_empty = commit_head != tail;

    // count includes this cycle's retirements
    assign retired_total = retired_cnt + commit_cnt_width'(commit_num);
    assign commit = not_empty && (retired_total > commit_cnt_width'(end_offset));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retired_cnt <= '0;
        end else if (commit) begin
            retired_cnt <= retired_total - end_count;
        end else begin
            retired_cnt <= retired_total;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            update_valid <= 1'b0;
        end else begin
            update_valid <= commit;
        end
    end

    // wb outcome replaces the prediction on a mispredict
    always_ff @(posedge clk) begin
        if (commit) begin
            update.start_addr <= commit_stream.start_addr;
            update.target <= head_mispred ? commit_wb.target : commit_stream.target;
            update.taken <= head_mispred ? commit_wb.taken : commit_stream.taken;
            update.end_offset <= end_offset;
            update.mispred <= head_mispred;
        end
    end

endmodule

//--- fsq_fetch_issue.sv
module fsq_fetch_issue (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pending,
    input  fsq_pkg::fsq_ptr_t      search_head,
    input  fsq_pkg::fetch_stream_t search_stream,
    input  logic                   cache_ready,
    input  logic                   flush,
    output logic                   issue,
    output fsq_pkg::cache_req_t    cache_req
);
    import fsq_pkg::*;

    logic          req_valid;
    fsq_ptr_t      req_ptr;
    fetch_stream_t req_stream;
    logic          load;

    // slot is free when empty or accepted on this edge
    assign load = ~req_valid | cache_ready;
    assign issue = load & pending & ~flush;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else if (flush) begin
            req_valid <= 1'b0;
        end else if (load) begin
            req_valid <= pending;
        end
    end

    // held unchanged under back-pressure
    always_ff @(posedge clk) begin
        if (issue) begin
            req_ptr <= search_head;
            req_stream <= search_stream;
        end
    end

    assign cache_req = '{valid: req_valid, ptr: req_ptr, stream: req_stream};

endmodule

//--- fsq_pkg.sv
package fsq_pkg;

    localparam int fsq_size = 8;
    localparam int fsq_width = 3;
    localparam int pred_width = 3;
    localparam int vaddr_size = 32;
    localparam int commit_width = 4;
    localparam int commit_cnt_width = 8;

    // index plus wrap direction
    typedef struct packed {
        logic                 dir;
        logic [fsq_width-1:0] idx;
    } fsq_ptr_t;

    // size is the offset of the last instruction in the stream
    typedef struct packed {
        logic [vaddr_size-1:0] start_addr;
        logic [pred_width-1:0] size;
        logic                  taken;
        logic [vaddr_size-1:0] target;
    } fetch_stream_t;

    typedef struct packed {
        logic                  taken;
        logic [vaddr_size-1:0] target;
        logic [pred_width-1:0] offset;
    } wb_info_t;

    // backend mispredict pulse
    typedef struct packed {
        logic                  valid;
        fsq_ptr_t              ptr;
        logic [pred_width-1:0] offset;
        logic                  taken;
        logic [vaddr_size-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic          valid;
        fsq_ptr_t      ptr;
        fetch_stream_t stream;
    } cache_req_t;

    typedef struct packed {
        logic [vaddr_size-1:0] start_addr;
        logic [vaddr_size-1:0] target;
        logic                  taken;
        logic [pred_width-1:0] end_offset;
        logic                  mispred;
    } update_t;

endpackage

//--- fsq_pointers.sv
module fsq_pointers (
    input  logic               clk,
    input  logic               rst,
    input  logic               enq,
    input  fsq_pkg::redirect_t redirect,
    input  logic               issue,
    input  logic               commit,
    output fsq_pkg::fsq_ptr_t  tail,
    output fsq_pkg::fsq_ptr_t  search_head,
    output fsq_pkg::fsq_ptr_t  commit_head,
    output logic               full,
    output logic               pending
);
    import fsq_pkg::*;

    logic     push;
    fsq_ptr_t redirect_next;
    fsq_ptr_t tail_next;
    fsq_ptr_t search_next;
    fsq_ptr_t commit_next;

    // step one entry, flip direction on rollover
    function automatic fsq_ptr_t ptr_inc(input fsq_ptr_t ptr);
        fsq_ptr_t nxt;
        if (ptr.idx == fsq_width'(fsq_size - 1)) begin
            nxt.dir = ~ptr.dir;
            nxt.idx = '0;
        end else begin
            nxt.dir = ptr.dir;
            nxt.idx = ptr.idx + 1'b1;
        end
        return nxt;
    endfunction

    assign full = (tail.idx == commit_head.idx) && (tail.dir != commit_head.dir);
    assign pending = search_head != tail;
    assign push = enq & ~full;

    assign redirect_next = ptr_inc(redirect.ptr);
    assign tail_next = ptr_inc(tail);
    assign search_next = ptr_inc(search_head);
    assign commit_next = ptr_inc(commit_head);

    // redirect restarts after the mispredicted stream
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail <= '0;
        end else if (redirect.valid) begin
            tail <= redirect_next;
        end else if (push) begin
            tail <= tail_next;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            search_head <= '0;
        end else if (redirect.valid) begin
            search_head <= redirect_next;
        end else if (issue) begin
            search_head <= search_next;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_head <= '0;
        end else if (commit) begin
            commit_head <= commit_next;
        end
    end

endmodule

//--- fsq_ram.sv
module fsq_ram #(
    parameter type entry_t = logic
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          we,
    input  logic [fsq_pkg::fsq_width-1:0] waddr,
    input  entry_t                        wdata,
    input  logic [fsq_pkg::fsq_width-1:0] raddr_a,
    input  logic [fsq_pkg::fsq_width-1:0] raddr_b,
    output entry_t                        rdata_a,
    output entry_t                        rdata_b
);
    import fsq_pkg::*;

    entry_t mem [fsq_size];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < fsq_size; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // combinational reads, same cycle
    assign rdata_a = mem[raddr_a];
    assign rdata_b = mem[raddr_b];

endmodule

//--- fsq_tb.sv
module fsq_tb;
    import fsq_pkg::*;

    typedef struct {
        fetch_stream_t         stream;
        logic                  wrong;
        logic                  redir;
        logic [pred_width-1:0] r_offset;
        logic                  r_taken;
        logic [vaddr_size-1:0] r_target;
    } row_t;

    localparam int n_rows = 8;
    localparam int full_rows = fsq_size + 1;
    localparam int max_cycles = 60 * (n_rows + full_rows);

    logic                                clk;
    logic                                rst;
    logic                                bpu_valid;
    fetch_stream_t                       bpu_stream;
    logic                                bpu_stall;
    fsq_ptr_t                            bpu_ptr;
    cache_req_t                          cache_req;
    logic                                cache_ready;
    redirect_t                           redirect;
    logic [$clog2(commit_width + 1)-1:0] commit_num;
    logic                                update_valid;
    update_t                             update;

    row_t       rows [n_rows];
    cache_req_t accepted [$];
    fsq_ptr_t   expected_ptr;
    logic       update_expected;
    int         cycles;

    fsq_clock_gen u_clock_gen (.clk(clk), .rst(rst));

    fsq_top u_dut (
        .clk(clk),
        .rst(rst),
        .bpu_valid(bpu_valid),
        .bpu_stream(bpu_stream),
        .bpu_stall(bpu_stall),
        .bpu_ptr(bpu_ptr),
        .cache_req(cache_req),
        .cache_ready(cache_ready),
        .redirect(redirect),
        .commit_num(commit_num),
        .update_valid(update_valid),
        .update(update)
    );

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_cache(input string name, input cache_req_t exp, input cache_req_t act);
        if (act !== exp) begin
            fail_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_update(input string name, input update_t exp, input update_t act);
        if (act !== exp) begin
            fail_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_ptr(input string name, input fsq_ptr_t exp, input fsq_ptr_t act);
        if (act !== exp) begin
            fail_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // 4-bit add carries the index rollover into the wrap bit
    function automatic fsq_ptr_t ptr_next(input fsq_ptr_t p);
        logic [fsq_width:0] v;
        v = p;
        v = v + 1'b1;
        return v;
    endfunction

    // one cycle; watches the cache handshake of the edge just passed
    task automatic tick();
        cache_req_t req_before;
        logic       ready_before;
        logic       flush_before;
        req_before = cache_req;
        ready_before = cache_ready;
        flush_before = redirect.valid;
        @(negedge clk);
        if (flush_before) begin
            check_flag("flush cache valid", 1'b0, cache_req.valid);
        end else if (req_before.valid && ready_before) begin
            accepted.push_back(req_before);
        end else if (req_before.valid) begin
            check_cache("held cache request", req_before, cache_req);
        end
        if (update_valid && !update_expected) begin
            fail_run("update_valid rose although no stream was due to commit");
        end
        cache_ready = ($urandom % 4) != 0;
        commit_num = '0;
        redirect = '0;
    endtask

    task automatic enqueue(input string name, input fetch_stream_t s);
        logic stalled;
        bpu_valid = 1'b1;
        bpu_stream = s;
        stalled = 1'b1;
        while (stalled) begin
            stalled = bpu_stall;
            if (!stalled) begin
                check_ptr(name, expected_ptr, bpu_ptr);
            end
            tick();
        end
        bpu_valid = 1'b0;
        expected_ptr = ptr_next(expected_ptr);
    endtask

    task automatic wait_accept(input string name, input fsq_ptr_t p, input fetch_stream_t s);
        cache_req_t exp;
        exp = '{valid: 1'b1, ptr: p, stream: s};
        while (accepted.size() == 0) begin
            tick();
        end
        check_cache(name, exp, accepted.pop_front());
    endtask

    // retires end offset plus 1 instructions in random chunks
    task automatic retire_row(input string name, input row_t r);
        update_t exp;
        int      left;
        int      chunk;
        exp.start_addr = r.stream.start_addr;
        exp.target = r.redir ? r.r_target : r.stream.target;
        exp.taken = r.redir ? r.r_taken : r.stream.taken;
        exp.end_offset = r.redir ? r.r_offset : r.stream.size;
        exp.mispred = r.redir;
        left = int'(exp.end_offset) + 1;
        while (left > 0) begin
            chunk = 1 + int'($urandom % commit_width);
            if (chunk > left) begin
                chunk = left;
            end
            commit_num = chunk[$clog2(commit_width + 1)-1:0];
            left = left - chunk;
            update_expected = (left == 0);
            tick();
        end
        check_flag({name, " valid"}, 1'b1, update_valid);
        check_update(name, exp, update);
        update_expected = 1'b0;
    endtask

    task automatic run_table();
        fsq_ptr_t row_ptr;
        logic     follower;
        for (int i = 0; i < n_rows; i++) begin
            if (!rows[i].wrong) begin
                follower = (i + 1 < n_rows) && rows[i + 1].wrong;
                row_ptr = expected_ptr;
                enqueue($sformatf("row %0d tail", i), rows[i].stream);
                if (follower) begin
                    enqueue($sformatf("row %0d tail", i + 1), rows[i + 1].stream);
                end
                wait_accept($sformatf("row %0d cache", i), row_ptr, rows[i].stream);
                if (rows[i].redir) begin
                    redirect = '{valid: 1'b1, ptr: row_ptr, offset: rows[i].r_offset,
                                 taken: rows[i].r_taken, target: rows[i].r_target};
                    tick();
                    expected_ptr = ptr_next(row_ptr);
                end
                retire_row($sformatf("row %0d update", i), rows[i]);
            end
        end
    endtask

    task automatic run_full();
        row_t     fs [full_rows];
        fsq_ptr_t fp [full_rows];
        for (int k = 0; k < full_rows; k++) begin
            fs[k] = '{default: '0};
            fs[k].stream.start_addr = 32'h0000_8000 + 32'(k) * 32'h40;
            fs[k].stream.size = pred_width'(k);
            fs[k].stream.taken = k[0];
            fs[k].stream.target = 32'h0000_9000 + 32'(k);
        end
        check_flag("stall before full phase", 1'b0, bpu_stall);
        for (int k = 0; k < fsq_size; k++) begin
            fp[k] = expected_ptr;
            enqueue($sformatf("full row %0d tail", k), fs[k].stream);
        end
        check_flag("stall with queue full", 1'b1, bpu_stall);
        fp[fsq_size] = expected_ptr;
        bpu_valid = 1'b1;
        bpu_stream = fs[fsq_size].stream;
        repeat (4) begin
            tick();
            check_flag("stall under held write", 1'b1, bpu_stall);
            check_ptr("tail under held write", fp[fsq_size], bpu_ptr);
        end
        bpu_valid = 1'b0;
        for (int k = 0; k < full_rows; k++) begin
            wait_accept($sformatf("full row %0d cache", k), fp[k], fs[k].stream);
            retire_row($sformatf("full row %0d update", k), fs[k]);
            if (k == 0) begin
                check_flag("stall after one commit", 1'b0, bpu_stall);
                enqueue($sformatf("full row %0d tail", fsq_size), fs[fsq_size].stream);
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            cycles <= cycles + 1;
            if (cycles >= max_cycles) begin
                fail_run($sformatf("run did not finish within %0d cycles", max_cycles));
            end
        end
    end

    initial begin
        bpu_valid = 1'b0;
        bpu_stream = '0;
        cache_ready = 1'b0;
        redirect = '0;
        commit_num = '0;
        update_expected = 1'b0;
        expected_ptr = '0;
        cycles = 0;
        void'($urandom(32'hb057));
        // stream {start, size, taken, target}, wrong path, redirect, offset, taken, target
        rows[0] = '{'{32'h0000_1000, 3'd7, 1'b0, 32'h0}, 1'b0, 1'b0, 3'd0, 1'b0, 32'h0};
        rows[1] = '{'{32'h0000_1020, 3'd3, 1'b1, 32'h2000}, 1'b0, 1'b0, 3'd0, 1'b0, 32'h0};
        rows[2] = '{'{32'h0000_2000, 3'd5, 1'b1, 32'h3000}, 1'b0, 1'b1, 3'd5, 1'b0, 32'h2018};
        rows[3] = '{'{32'h0000_3000, 3'd4, 1'b0, 32'h0}, 1'b1, 1'b0, 3'd0, 1'b0, 32'h0};
        rows[4] = '{'{32'h0000_2018, 3'd6, 1'b0, 32'h0}, 1'b0, 1'b1, 3'd1, 1'b1, 32'h4000};
        rows[5] = '{'{32'h0000_2020, 3'd7, 1'b0, 32'h0}, 1'b1, 1'b0, 3'd0, 1'b0, 32'h0};
        rows[6] = '{'{32'h0000_4000, 3'd2, 1'b1, 32'h5000}, 1'b0, 1'b0, 3'd0, 1'b0, 32'h0};
        rows[7] = '{'{32'h0000_5000, 3'd0, 1'b0, 32'h0}, 1'b0, 1'b1, 3'd0, 1'b1, 32'h6000};
        @(negedge rst);
        check_flag("reset cache valid", 1'b0, cache_req.valid);
        check_flag("reset update valid", 1'b0, update_valid);
        check_flag("reset stall", 1'b0, bpu_stall);
        run_table();
        run_full();
        repeat (4) tick();
        if (accepted.size() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            fail_run("cache accepted more streams than the queue held");
        end
    end

endmodule

//--- fsq_top.sv
module fsq_top (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          bpu_valid,
    input  fsq_pkg::fetch_stream_t                        bpu_stream,
    output logic                                          bpu_stall,
    output fsq_pkg::fsq_ptr_t                             bpu_ptr,
    output fsq_pkg::cache_req_t                           cache_req,
    input  logic                                          cache_ready,
    input  fsq_pkg::redirect_t                            redirect,
    input  logic [$clog2(fsq_pkg::commit_width + 1)-1:0] commit_num,
    output logic                                          update_valid,
    output fsq_pkg::update_t                              update
);
    import fsq_pkg::*;

    fsq_ptr_t      search_head;
    fsq_ptr_t      commit_head;
    fetch_stream_t search_stream;
    fetch_stream_t commit_stream;
    logic          queue_we;
    logic          pending;
    logic          issue;
    logic          commit;

    assign queue_we = bpu_valid & ~bpu_stall;

    // port a feeds the cache, port b the commit
    fsq_ram #(
        .entry_t(fetch_stream_t)
    ) u_stream_ram (
        .clk(clk),
        .rst(rst),
        .we(queue_we),
        .waddr(bpu_ptr.idx),
        .wdata(bpu_stream),
        .raddr_a(search_head.idx),
        .raddr_b(commit_head.idx),
        .rdata_a(search_stream),
        .rdata_b(commit_stream)
    );

    fsq_pointers u_pointers (
        .clk(clk),
        .rst(rst),
        .enq(bpu_valid),
        .redirect(redirect),
        .issue(issue),
        .commit(commit),
        .tail(bpu_ptr),
        .search_head(search_head),
        .commit_head(commit_head),
        .full(bpu_stall),
        .pending(pending)
    );

    fsq_fetch_issue u_fetch_issue (
        .clk(clk),
        .rst(rst),
        .pending(pending),
        .search_head(search_head),
        .search_stream(search_stream),
        .cache_ready(cache_ready),
        .flush(redirect.valid),
        .issue(issue),
        .cache_req(cache_req)
    );

    fsq_commit u_commit (
        .clk(clk),
        .rst(rst),
        .commit_head(commit_head),
        .commit_stream(commit_stream),
        .redirect(redirect),
        .enq(queue_we),
        .tail(bpu_ptr),
        .commit_num(commit_num),
        .commit(commit),
        .update_valid(update_valid),
        .update(update)
    );

endmodule

//--- list.f
fsq_pkg.sv
fsq_ram.sv
fsq_pointers.sv
fsq_fetch_issue.sv
fsq_commit.sv
fsq_top.sv
fsq_clock_gen.sv
fsq_assert.sv
fsq_tb.sv
